// ==== include/csa_funcs.svh ====
`ifndef CSA_FUNCS_SVH
`define CSA_FUNCS_SVH

// Needs mul_reduce_pkg imported in the including scope (col_t, csa_t)

// Bitwise 3:2 compressor over one byte column
function automatic csa_t csa_3to2(input col_t a, input col_t b, input col_t c);
    csa_t res;
    res.sum   = a ^ b ^ c;
    res.carry = ((a & b) | (b & c) | (a & c)) << 1;    // Majority moves up one bit
    return res;
endfunction

// Resolves a carry-save pair into one column value
function automatic col_t add_sum_carry(input csa_t v);
    return v.sum + v.carry;
endfunction

`endif

// ==== rtl/mul_reduce_pkg.sv ====
package mul_reduce_pkg;

    localparam int PP_COUNT = 8;     // Partial products per beat
    localparam int PP_W     = 16;    // One unsigned 8x8 product
    localparam int PROD_W   = 64;
    localparam int BYTE_W   = 8;
    localparam int NUM_COLS = PROD_W / BYTE_W;    // Byte columns of the weighted sum
    localparam int COL_W    = 11;    // Holds eight bytes of one column
    localparam int LANE8_W  = 16;    // Result lane width in 8-bit mode
    localparam int LANE16_W = 32;    // Result lane width in 16-bit mode
    localparam int LANES_8  = PROD_W / LANE8_W;
    localparam int LANES_16 = PROD_W / LANE16_W;

    typedef logic [PP_W-1:0]   pp_t;
    typedef logic [PROD_W-1:0] prod_t;
    typedef logic [3:0]        sign_t;    // One sign bit per operand byte
    typedef logic [COL_W-1:0]  col_t;
    typedef logic [2:0]        boff_t;    // Byte offset of a partial product

    typedef enum logic [1:0] {
        SEW_8    = 2'd0,
        SEW_16   = 2'd1,
        SEW_32   = 2'd2,
        SEW_RSVD = 2'd3
    } sew_t;

    // prods[0] is pp1, prods[7] is pp8
    typedef struct packed {
        pp_t [PP_COUNT-1:0] prods;
    } pp_beat_t;

    typedef struct packed {
        sew_t  sew;
        sign_t sign_a;
        sign_t sign_b;
        logic  last_beat;    // Beat completes the operation
        prod_t sum;
    } stage_data_t;

    // Output pair of a 3:2 compressor, carry already at its own weight
    typedef struct packed {
        col_t carry;
        col_t sum;
    } csa_t;

    // Byte offsets, indexed by pp number minus one
    // 8-bit: pp1..pp4 alone in 16-bit lanes, pp5..pp8 unused
    localparam boff_t BOFF_8  [PP_COUNT] = '{3'd0, 3'd2, 3'd4, 3'd6, 3'd0, 3'd0, 3'd0, 3'd0};
    // 16-bit: a0b0 a0b1 a1b0 a1b1 for lane 0, then the same for lane 1
    localparam boff_t BOFF_16 [PP_COUNT] = '{3'd0, 3'd1, 3'd1, 3'd2, 3'd4, 3'd5, 3'd5, 3'd6};
    // 32-bit beat one: a0b0..a0b3, then a1b0..a1b3
    localparam boff_t BOFF_32 [PP_COUNT] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd1, 3'd2, 3'd3, 3'd4};
    localparam boff_t BEAT2_SHIFT = 3'd2;    // Beat two carries a2 and a3
    localparam logic [PP_COUNT-1:0] USED_8 = 8'b0000_1111;

    function automatic boff_t pp_byte_offset(sew_t sew, logic second_beat, int idx);
        boff_t off;
        case (sew)
            SEW_8:   off = BOFF_8[idx];
            SEW_16:  off = BOFF_16[idx];
            default: off = BOFF_32[idx];
        endcase
        if (second_beat)
            off = off + BEAT2_SHIFT;
        return off;
    endfunction

    function automatic logic pp_used(sew_t sew, int idx);
        if (sew == SEW_8)
            return USED_8[idx];
        return sew != SEW_RSVD;
    endfunction

endpackage

// ==== rtl/pp_reduce_stage.sv ====
`timescale 1ns/1ps

module pp_reduce_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  mul_reduce_pkg::sew_t      sew,
    input  mul_reduce_pkg::pp_beat_t  pp,
    input  mul_reduce_pkg::sign_t     sign_a,
    input  mul_reduce_pkg::sign_t     sign_b,
    output logic                      reduce_valid,
    output mul_reduce_pkg::stage_data_t reduce_data
);
    import mul_reduce_pkg::*;

    `include "csa_funcs.svh"

    typedef enum logic {
        BEAT_IDLE,
        BEAT_SECOND    // 32-bit operation waits for a2/a3 beat
    } beat_state_t;

    beat_state_t state, state_next;

    sew_t        held_sew;
    sign_t       held_sign_a;
    sign_t       held_sign_b;
    logic        second_beat;
    logic        first_ok;
    logic        open_wide;
    logic        beat_valid;
    sew_t        beat_sew;
    stage_data_t beat_data;
    prod_t       weighted_sum;

    // Candidate bytes per column, one slot per partial product
    col_t [PP_COUNT-1:0] col_in [NUM_COLS];

    // Carry-save chain over all slots of a column
    function automatic col_t reduce_column(input col_t [PP_COUNT-1:0] grp);
        csa_t acc;
        acc.sum   = grp[0];
        acc.carry = grp[1];
        for (int i = 2; i < PP_COUNT; i++)
            acc = csa_3to2(acc.sum, acc.carry, grp[i]);
        return add_sum_carry(acc);
    endfunction

    assign second_beat = (state == BEAT_SECOND);
    assign first_ok    = start && (sew != SEW_RSVD) && !second_beat;  // Reserved mode dropped
    assign open_wide   = first_ok && (sew == SEW_32);
    assign beat_valid  = second_beat || first_ok;
    assign beat_sew    = second_beat ? held_sew : sew;

    always_comb begin
        state_next = state;
        case (state)
            BEAT_IDLE:   if (open_wide) state_next = BEAT_SECOND;
            BEAT_SECOND: state_next = BEAT_IDLE;
            default:     state_next = BEAT_IDLE;
        endcase
    end

    // Place low and high byte of every product in its column
    always_comb begin
        boff_t off;
        for (int c = 0; c < NUM_COLS; c++)
            col_in[c] = '0;
        for (int i = 0; i < PP_COUNT; i++) begin
            off = pp_byte_offset(beat_sew, second_beat, i);
            if (pp_used(beat_sew, i)) begin
                col_in[off][i] = col_t'(pp.prods[i][BYTE_W-1:0]);
                // Tables keep every offset below the top column
                col_in[boff_t'(off + 3'd1)][i] = col_t'(pp.prods[i][PP_W-1:BYTE_W]);
            end
        end
    end

    // Ripple the column results into 8-bit chunks
    always_comb begin
        col_t                    chunk;
        logic [COL_W-BYTE_W-1:0] carry;
        carry = '0;
        for (int c = 0; c < NUM_COLS; c++) begin
            chunk = reduce_column(col_in[c]) + col_t'(carry);
            weighted_sum[BYTE_W*c +: BYTE_W] = chunk[BYTE_W-1:0];
            carry = chunk[COL_W-1:BYTE_W];
        end
    end

    always_comb begin
        beat_data.sew       = beat_sew;
        beat_data.sign_a    = second_beat ? held_sign_a : sign_a;
        beat_data.sign_b    = second_beat ? held_sign_b : sign_b;
        beat_data.last_beat = !(beat_sew == SEW_32 && !second_beat);
        beat_data.sum       = weighted_sum;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= BEAT_IDLE;
            reduce_valid <= 1'b0;
        end else begin
            state        <= state_next;
            reduce_valid <= beat_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (open_wide) begin    // Mode and signs are sampled once per operation
            held_sew    <= sew;
            held_sign_a <= sign_a;
            held_sign_b <= sign_b;
        end
        if (beat_valid)
            reduce_data <= beat_data;
    end

endmodule

// ==== rtl/beat_accumulate_stage.sv ====
`timescale 1ns/1ps

module beat_accumulate_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        reduce_valid,
    input  mul_reduce_pkg::stage_data_t reduce_data,
    output logic                        acc_valid,
    output mul_reduce_pkg::stage_data_t acc_data
);
    import mul_reduce_pkg::*;

    prod_t partial;         // Beat one sum of a 32-bit operation
    logic  pending;         // Partial waits for its second beat
    logic  take_partial;
    logic  take_last;
    prod_t joined;

    assign take_partial = reduce_valid && !reduce_data.last_beat;
    assign take_last    = reduce_valid && reduce_data.last_beat;

    // Beat two already sits 16 bits higher, so a plain add joins them
    assign joined = pending ? reduce_data.sum + partial : reduce_data.sum;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc_valid <= 1'b0;
            pending   <= 1'b0;
        end else begin
            acc_valid <= take_last;
            if (take_partial)
                pending <= 1'b1;
            else if (take_last)
                pending <= 1'b0;    // Used up, never added twice
        end
    end

    always_ff @(posedge clk) begin
        if (take_partial)
            partial <= reduce_data.sum;
        if (take_last) begin
            acc_data     <= reduce_data;
            acc_data.sum <= joined;
        end
    end

endmodule

// ==== rtl/sign_fix_stage.sv ====
`timescale 1ns/1ps

module sign_fix_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        acc_valid,
    input  mul_reduce_pkg::stage_data_t acc_data,
    output logic                        done,
    output mul_reduce_pkg::prod_t       product
);
    import mul_reduce_pkg::*;

    prod_t fixed;

    // Two's complement per lane where the operand signs differ
    always_comb begin
        sign_t neg;
        neg   = acc_data.sign_a ^ acc_data.sign_b;
        fixed = acc_data.sum;
        case (acc_data.sew)
            SEW_8: begin
                for (int k = 0; k < LANES_8; k++) begin
                    if (neg[k])
                        fixed[LANE8_W*k +: LANE8_W] = ~acc_data.sum[LANE8_W*k +: LANE8_W] + 1'b1;
                end
            end
            SEW_16: begin
                for (int k = 0; k < LANES_16; k++) begin
                    if (neg[2*k+1])    // Sign of the upper operand byte
                        fixed[LANE16_W*k +: LANE16_W] =
                            ~acc_data.sum[LANE16_W*k +: LANE16_W] + 1'b1;
                end
            end
            SEW_32: begin
                if (neg[3])
                    fixed = ~acc_data.sum + 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done    <= 1'b0;
            product <= '0;
        end else begin
            done <= acc_valid;
            if (acc_valid)
                product <= fixed;    // Holds last result between operations
        end
    end

endmodule

// ==== rtl/vec_mul_reduce_top.sv ====
`timescale 1ns/1ps

module vec_mul_reduce_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  mul_reduce_pkg::sew_t     sew,
    input  mul_reduce_pkg::pp_beat_t pp,
    input  mul_reduce_pkg::sign_t    sign_a,
    input  mul_reduce_pkg::sign_t    sign_b,
    output logic                     done,
    output mul_reduce_pkg::prod_t    product
);
    import mul_reduce_pkg::*;

    logic        reduce_valid;
    stage_data_t reduce_data;
    logic        acc_valid;
    stage_data_t acc_data;

    // Stage 1: byte columns reduced into one weighted sum per beat
    pp_reduce_stage u_reduce (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .sew          (sew),
        .pp           (pp),
        .sign_a       (sign_a),
        .sign_b       (sign_b),
        .reduce_valid (reduce_valid),
        .reduce_data  (reduce_data)
    );

    // Stage 2: joins the two beats of a 32-bit operation
    beat_accumulate_stage u_accumulate (
        .clk          (clk),
        .reset        (reset),
        .reduce_valid (reduce_valid),
        .reduce_data  (reduce_data),
        .acc_valid    (acc_valid),
        .acc_data     (acc_data)
    );

    // Stage 3
    sign_fix_stage u_sign (
        .clk       (clk),
        .reset     (reset),
        .acc_valid (acc_valid),
        .acc_data  (acc_data),
        .done      (done),
        .product   (product)
    );

endmodule

// ==== sim/vec_mul_reduce_assert.sv ====
`timescale 1ns/1ps

module vec_mul_reduce_assert (
    input logic                 clk,
    input logic                 reset,
    input logic                 start,
    input mul_reduce_pkg::sew_t sew,
    input logic                 done
);
    import mul_reduce_pkg::*;

    // Reset forces the output stage quiet
    done_low_in_reset: assert property (
        @(posedge clk) reset |-> !done
    ) else $error("done is high while reset is held");

    // Narrow modes return in 3 cycles, 32-bit mode in 4
    done_has_start: assert property (
        @(posedge clk) disable iff (reset)
        done |-> ($past(start, 3) && ($past(sew, 3) == SEW_8 || $past(sew, 3) == SEW_16))
              || ($past(start, 4) && $past(sew, 4) == SEW_32)
    ) else $error("done without a matching start 3 or 4 cycles earlier");

    // Second beat slot of a 32-bit operation
    no_start_on_beat_two: assert property (
        @(posedge clk) disable iff (reset)
        (start && sew == SEW_32) |=> !start
    ) else $error("start asserted in the second beat cycle of a 32-bit operation");

    reserved_gives_no_done: assert property (
        @(posedge clk) disable iff (reset)
        done |-> !($past(start, 3) && $past(sew, 3) == SEW_RSVD)
    ) else $error("done followed a start with the reserved mode");

endmodule

bind vec_mul_reduce_top vec_mul_reduce_assert u_assert (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .sew   (sew),
    .done  (done)
);

// ==== sim/tb_vec_mul_reduce.sv ====
`timescale 1ns/1ps

module tb_vec_mul_reduce;
    import mul_reduce_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int OPS_PER_MODE  = 50;
    localparam int MIXED_OPS     = 60;
    localparam int RSVD_OPS      = 12;
    localparam int TOTAL_OPS     = 3 * OPS_PER_MODE + MIXED_OPS + RSVD_OPS + 2;
    localparam int CYCLES_PER_OP = 6;

    logic     clk;
    logic     reset;
    logic     start;
    sew_t     sew;
    pp_beat_t pp;
    sign_t    sign_a;
    sign_t    sign_b;
    logic     done;
    prod_t    product;

    prod_t exp_q[$];    // Expected products in start order
    int    due_q[$];    // Cycle in which each done is due
    string test_name;
    int    cycle;
    int    error_count;
    int    check_count;
    int    tests_passed;
    int    tests_failed;
    int    errors_at_test_start;

    vec_mul_reduce_top u_dut (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .sew     (sew),
        .pp      (pp),
        .sign_a  (sign_a),
        .sign_b  (sign_b),
        .done    (done),
        .product (product)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (RESET_CYCLES + TOTAL_OPS * CYCLES_PER_OP) @(posedge clk);
        $display("Watchdog expired while results were still missing in %s", test_name);
        $display("TEST FAILED");
        $finish;
    end

    // Magnitude of every lane of a signed operand
    function automatic logic [31:0] lane_magnitude(sew_t m, logic [31:0] v);
        logic [31:0] r;
        r = v;
        case (m)
            SEW_8: begin
                for (int k = 0; k < 4; k++)
                    if (v[8*k+7]) r[8*k +: 8] = ~v[8*k +: 8] + 8'd1;
            end
            SEW_16: begin
                for (int k = 0; k < 2; k++)
                    if (v[16*k+15]) r[16*k +: 16] = ~v[16*k +: 16] + 16'd1;
            end
            default: if (v[31]) r = ~v + 32'd1;
        endcase
        return r;
    endfunction

    // What the external 8x8 multiplier bank would produce
    function automatic pp_t byte_prod(logic [31:0] ma, logic [31:0] mb, int i, int j);
        pp_t x;
        pp_t y;
        x = pp_t'(ma[8*i +: 8]);
        y = pp_t'(mb[8*j +: 8]);
        return x * y;
    endfunction

    // Partial products of one beat in pp order 1 to 8
    function automatic pp_beat_t make_beat(sew_t m, logic [31:0] ma, logic [31:0] mb, int beat);
        pp_beat_t r;
        for (int i = 0; i < PP_COUNT; i++)
            r.prods[i] = pp_t'($urandom());    // Slots unused in the mode carry noise
        case (m)
            SEW_8: begin
                for (int k = 0; k < 4; k++)
                    r.prods[k] = byte_prod(ma, mb, k, k);
            end
            SEW_16: begin
                for (int l = 0; l < 2; l++) begin
                    r.prods[4*l]   = byte_prod(ma, mb, 2*l, 2*l);
                    r.prods[4*l+1] = byte_prod(ma, mb, 2*l, 2*l+1);
                    r.prods[4*l+2] = byte_prod(ma, mb, 2*l+1, 2*l);
                    r.prods[4*l+3] = byte_prod(ma, mb, 2*l+1, 2*l+1);
                end
            end
            default: begin
                for (int j = 0; j < 4; j++) begin
                    r.prods[j]   = byte_prod(ma, mb, 2*beat, j);      // a0 or a2 row
                    r.prods[4+j] = byte_prod(ma, mb, 2*beat+1, j);    // a1 or a3 row
                end
            end
        endcase
        return r;
    endfunction

    function automatic prod_t signed_product(sew_t m, logic [31:0] a, logic [31:0] b);
        logic signed [15:0] a8;
        logic signed [15:0] b8;
        logic signed [31:0] a16;
        logic signed [31:0] b16;
        logic signed [63:0] a32;
        logic signed [63:0] b32;
        prod_t              r;
        r = '0;
        case (m)
            SEW_8: begin
                for (int k = 0; k < 4; k++) begin
                    a8 = $signed(a[8*k +: 8]);
                    b8 = $signed(b[8*k +: 8]);
                    r[16*k +: 16] = a8 * b8;
                end
            end
            SEW_16: begin
                for (int k = 0; k < 2; k++) begin
                    a16 = $signed(a[16*k +: 16]);
                    b16 = $signed(b[16*k +: 16]);
                    r[32*k +: 32] = a16 * b16;
                end
            end
            default: begin
                a32 = $signed(a);
                b32 = $signed(b);
                r   = a32 * b32;
            end
        endcase
        return r;
    endfunction

    task automatic issue_op(sew_t m, logic [31:0] a, logic [31:0] b);
        logic [31:0] ma;
        logic [31:0] mb;
        ma = lane_magnitude(m, a);
        mb = lane_magnitude(m, b);
        exp_q.push_back(signed_product(m, a, b));
        @(posedge clk);
        start  <= 1'b1;
        sew    <= m;
        sign_a <= {a[31], a[23], a[15], a[7]};
        sign_b <= {b[31], b[23], b[15], b[7]};
        pp     <= make_beat(m, ma, mb, 0);
        if (m == SEW_32) begin
            @(posedge clk);
            start  <= 1'b0;
            sew    <= sew_t'($urandom());    // Mode and signs not sampled on beat two
            sign_a <= sign_t'($urandom());
            sign_b <= sign_t'($urandom());
            pp     <= make_beat(m, ma, mb, 1);
        end
    endtask

    task automatic issue_random(sew_t m);
        issue_op(m, $urandom(), $urandom());
    endtask

    task automatic issue_reserved();
        @(posedge clk);
        start  <= 1'b1;
        sew    <= SEW_RSVD;
        sign_a <= sign_t'($urandom());
        sign_b <= sign_t'($urandom());
        pp     <= make_beat(SEW_8, $urandom(), $urandom(), 0);
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            start <= 1'b0;
        end
    endtask

    task automatic drain_results();
        idle_cycles(1);
        while (exp_q.size() != 0)
            @(posedge clk);
    endtask

    function automatic sew_t random_mode();
        return sew_t'($urandom_range(2, 0));
    endfunction

    task automatic begin_test(string name);
        test_name = name;
        errors_at_test_start = error_count;
    endtask

    task automatic end_test();
        if (error_count == errors_at_test_start) begin
            tests_passed++;
            $display("%s finished, no errors", test_name);
        end else begin
            tests_failed++;
            $display("%s finished, %0d errors", test_name, error_count - errors_at_test_start);
        end
    endtask

    task automatic check_result();
        prod_t exp;
        int    due;
        assert (exp_q.size() != 0 && due_q.size() != 0)
        else begin
            $display("%s: done pulsed with no operation outstanding", test_name);
            error_count++;
        end
        if (exp_q.size() != 0 && due_q.size() != 0) begin
            exp = exp_q.pop_front();
            due = due_q.pop_front();
            check_count++;
            assert (product == exp)
            else begin
                $display("CHECK FAILED %s: product expected %h actual %h",
                         test_name, exp, product);
                error_count++;
            end
            assert (cycle == due)
            else begin
                $display("CHECK FAILED %s: done cycle expected %0d actual %0d",
                         test_name, due, cycle);
                error_count++;
            end
        end
    endtask

    // Monitor samples on the same edge the DUT does
    always @(posedge clk) begin
        if (reset) begin
            cycle = 0;
        end else begin
            cycle++;
            if (start && sew != SEW_RSVD)
                due_q.push_back(cycle + ((sew == SEW_32) ? 4 : 3));
            if (done)
                check_result();
        end
    end

    initial begin
        void'($urandom(51));
        error_count  = 0;
        check_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        reset  = 1'b1;
        start  = 1'b0;
        sew    = SEW_8;
        pp     = '0;
        sign_a = '0;
        sign_b = '0;
        test_name = "reset";

        begin_test("reset");
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (done == 1'b0 && product == '0)
        else begin
            $display("CHECK FAILED reset: done/product expected 0/%h actual %b/%h",
                     prod_t'(0), done, product);
            error_count++;
        end
        end_test();

        begin_test("sew8");
        for (int n = 0; n < OPS_PER_MODE; n++) begin
            issue_random(SEW_8);
            idle_cycles($urandom_range(2, 0));
        end
        drain_results();
        end_test();

        begin_test("sew16");
        issue_op(SEW_16, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        issue_op(SEW_16, 32'h8001_8000, 32'h8001_8001);    // Magnitudes 7FFF and 8000
        issue_op(SEW_16, 32'h7FFF_8000, 32'h7FFF_8000);
        for (int n = 3; n < OPS_PER_MODE; n++) begin
            issue_random(SEW_16);
            idle_cycles($urandom_range(2, 0));
        end
        drain_results();
        end_test();

        begin_test("sew32");
        issue_op(SEW_32, 32'h8000_0000, 32'h8000_0000);
        issue_op(SEW_32, 32'h8000_0001, 32'h7FFF_FFFF);
        for (int n = 2; n < OPS_PER_MODE; n++) begin
            issue_random(SEW_32);
            idle_cycles($urandom_range(2, 0));
        end
        drain_results();
        end_test();

        begin_test("back_to_back");
        for (int n = 0; n < MIXED_OPS; n++)
            issue_random(random_mode());
        drain_results();
        end_test();

        begin_test("reserved");
        issue_reserved();
        idle_cycles(6);
        for (int n = 0; n < RSVD_OPS; n++) begin
            if (n == RSVD_OPS / 2)
                issue_reserved();    // Reserved start inside a stream
            issue_random(random_mode());
        end
        drain_results();
        end_test();

        $display("Summary: %0d tests passed, %0d tests failed, %0d results checked, %0d errors",
                 tests_passed, tests_failed, check_count, error_count);
        if (error_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
rtl/mul_reduce_pkg.sv
rtl/pp_reduce_stage.sv
rtl/beat_accumulate_stage.sv
rtl/sign_fix_stage.sv
rtl/vec_mul_reduce_top.sv
sim/vec_mul_reduce_assert.sv
sim/tb_vec_mul_reduce.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the vector multiplier reduction testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_vec_mul_reduce \
    -f project.f \
    -o tb_vec_mul_reduce

./obj_dir/tb_vec_mul_reduce > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"
exit 0
